// File: sparse_feeder.f
+incdir+common
common/sparse_feeder_pkg.sv
storage/sp_ram.sv
storage/weight_store.sv
storage/act_store.sv
sparsity/flag_scanner.sv
src/feed_ctrl.sv
src/sparse_feeder.sv
bench/tb_sparse_feeder.sv

// File: bench/tb_sparse_feeder.sv
`timescale 1ns/100ps
`include "sparse_feeder_macros.svh"

module tb_sparse_feeder;

  import sparse_feeder_pkg::*;

  localparam int NUM_JOBS    = 15;
  localparam int LOAD_CYCLES = 20 * NUM_JOBS + 40;  // up to ten two-cycle writes per job
  localparam int MAX_CYCLES  = 50 * NUM_JOBS + LOAD_CYCLES;

  logic     clk;
  logic     reset;
  flag_wr_t flag_wr_i;
  wei_wr_t  wei_wr_i;
  act_wr_t  act_wr_i;
  logic     start_i;
  beat_t    beat_o;
  logic     valid_o;
  logic     done_o;
  logic     busy_o;
  count_t   nz_count_o;
  logic     zero_o;

  // reference model consumed in job order
  flag_mask_t mask_q[$];
  act_block_t block_q[$];
  pix_t       wei_q[$];

  int     cycles;
  int     jobs_done;
  int     starts_accepted;
  integer seed;

  sparse_feeder u_dut (
    .clk        (clk),
    .reset      (reset),
    .flag_wr_i  (flag_wr_i),
    .wei_wr_i   (wei_wr_i),
    .act_wr_i   (act_wr_i),
    .start_i    (start_i),
    .beat_o     (beat_o),
    .valid_o    (valid_o),
    .done_o     (done_o),
    .busy_o     (busy_o),
    .nz_count_o (nz_count_o),
    .zero_o     (zero_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout waiting for done");
      $display("Something failed");
      $fatal(1, "run stopped at cycle limit");
    end
  end

  always @(negedge clk) begin
    if (done_o) jobs_done = jobs_done + 1;
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "check failed");
    end
  endtask

  // ------------------------------------------------------------
  // store loading
  // ------------------------------------------------------------
  task automatic load_job(input flag_mask_t mask, input act_block_t blk);
    @(posedge clk);
    #1;
    flag_wr_i = '{valid: 1'b1, mask: mask};
    act_wr_i  = '{valid: 1'b1, block: blk};
    @(posedge clk);
    #1;
    flag_wr_i = '0;
    act_wr_i  = '0;
    mask_q.push_back(mask);
    block_q.push_back(blk);
  endtask

  task automatic load_weight(input pix_t w);
    @(posedge clk);
    #1;
    wei_wr_i = '{valid: 1'b1, data: w};
    @(posedge clk);
    #1;
    wei_wr_i = '0;
    wei_q.push_back(w);
  endtask

  // runs one job and pulses extra starts while busy
  task automatic run_job(input int extra_starts);
    flag_mask_t mask;
    act_block_t blk;
    int         exp_pos[$];
    int         beats;
    int         cyc;
    bit         done_seen;
    mask = mask_q.pop_front();
    blk  = block_q.pop_front();
    for (int p = 0; p < `SF_KERNEL_SIZE; p++) begin
      if (mask[p]) exp_pos.push_back(p);  // ascending taps
    end
    beats     = 0;
    cyc       = 0;
    done_seen = 1'b0;
    @(posedge clk);
    #1 start_i = 1'b1;
    @(posedge clk);  // start sampled here
    #1 start_i = 1'b0;
    starts_accepted++;
    while (!done_seen) begin
      start_i = (cyc < extra_starts);
      @(negedge clk);
      if (valid_o) begin
        if (beats >= exp_pos.size()) check_value("extra beat", beats + 1, exp_pos.size());
        check_value("beat cycle", cyc, 3 + beats);
        check_value("beat weight", beat_o.weight, wei_q.pop_front());
        check_value("beat pos", beat_o.pos, exp_pos[beats]);
        check_value("beat act", beat_o.act, blk[exp_pos[beats]]);
        beats++;
      end
      if (done_o) begin
        done_seen = 1'b1;
        check_value("done cycle", cyc, 3 + exp_pos.size());
        check_value("nonzero count", nz_count_o, exp_pos.size());
        check_value("zero flag", zero_o, exp_pos.size() == 0);
        check_value("busy at done", busy_o, 0);
      end else begin
        check_value("busy during job", busy_o, 1);
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    start_i = 1'b0;
    check_value("beat count", beats, exp_pos.size());
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_test();
    @(negedge clk);
    check_value("valid after reset", valid_o, 0);
    check_value("done after reset", done_o, 0);
    check_value("busy after reset", busy_o, 0);
    check_value("zero after reset", zero_o, 0);
  endtask

  task automatic dense_test();
    act_block_t blk;
    for (int p = 0; p < `SF_KERNEL_SIZE; p++) blk[p] = pix_t'(8'ha0 + p);
    load_job(9'h1ff, blk);
    for (int i = 0; i < `SF_KERNEL_SIZE; i++) load_weight(pix_t'(i + 1));
    run_job(0);
  endtask

  task automatic sparse_test();
    flag_mask_t masks[3] = '{9'b000010101, 9'b100000001, 9'b011110000};
    act_block_t blk;
    int         n;
    n = 0;
    for (int j = 0; j < 3; j++) begin
      for (int p = 0; p < `SF_KERNEL_SIZE; p++) blk[p] = pix_t'((j << 4) | p);
      load_job(masks[j], blk);
      for (int p = 0; p < `SF_KERNEL_SIZE; p++) begin
        if (masks[j][p]) begin
          load_weight(pix_t'(8'h40 + n));
          n++;
        end
      end
    end
    for (int j = 0; j < 3; j++) run_job(0);  // weights carry across jobs
  endtask

  task automatic zero_test();
    act_block_t blk;
    for (int p = 0; p < `SF_KERNEL_SIZE; p++) blk[p] = pix_t'(8'h60 + p);
    load_job('0, blk);
    load_job(9'b000000110, blk);
    load_weight(8'h77);
    load_weight(8'h78);
    run_job(0);
    run_job(0);
  endtask

  task automatic random_test();
    flag_mask_t mask;
    act_block_t blk;
    for (int j = 0; j < 8; j++) begin
      mask = flag_mask_t'($random(seed));
      for (int p = 0; p < `SF_KERNEL_SIZE; p++) blk[p] = pix_t'($random(seed));
      load_job(mask, blk);
      for (int p = 0; p < `SF_KERNEL_SIZE; p++) begin
        if (mask[p]) load_weight(pix_t'($random(seed)));
      end
    end
    for (int j = 0; j < 8; j++) run_job(0);
  endtask

  task automatic ignored_start_test();
    act_block_t blk;
    for (int p = 0; p < `SF_KERNEL_SIZE; p++) blk[p] = pix_t'(8'hc0 + p);
    load_job(9'b101010101, blk);
    for (int i = 0; i < 5; i++) load_weight(pix_t'(8'hd0 + i));
    run_job(3);
    repeat (10) begin
      @(negedge clk);
      check_value("no beat after job", valid_o, 0);
      check_value("idle after job", busy_o, 0);
    end
    check_value("completed jobs", jobs_done, starts_accepted);
  endtask

  initial begin
    clk             = 1'b0;
    reset           = 1'b0;
    start_i         = 1'b0;
    flag_wr_i       = '0;
    wei_wr_i        = '0;
    act_wr_i        = '0;
    cycles          = 0;
    jobs_done       = 0;
    starts_accepted = 0;
    seed            = 4;
    repeat (8) @(posedge clk);
    #1 reset = 1'b1;
    reset_test();
    dense_test();
    sparse_test();
    zero_test();
    random_test();
    ignored_start_test();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: src/sparse_feeder.sv
`timescale 1ns/100ps

module sparse_feeder (
  input  logic                        clk,
  input  logic                        reset,
  input  sparse_feeder_pkg::flag_wr_t flag_wr_i,
  input  sparse_feeder_pkg::wei_wr_t  wei_wr_i,
  input  sparse_feeder_pkg::act_wr_t  act_wr_i,
  input  logic                        start_i,
  output sparse_feeder_pkg::beat_t    beat_o,
  output logic                        valid_o,
  output logic                        done_o,
  output logic                        busy_o,
  output sparse_feeder_pkg::count_t   nz_count_o,
  output logic                        zero_o
);

  import sparse_feeder_pkg::*;

  logic       job_rd;
  logic       scan_load;
  logic       take;
  logic       last;
  pos_t       scan_pos;
  pos_t       beat_pos;
  count_t     scan_count;
  flag_mask_t mask;
  pix_t       weight;
  pix_t       act;

  weight_store u_weight_store (
    .clk       (clk),
    .reset     (reset),
    .flag_wr_i (flag_wr_i),
    .wei_wr_i  (wei_wr_i),
    .job_rd_i  (job_rd),
    .take_i    (take),
    .mask_o    (mask),
    .weight_o  (weight)
  );

  act_store u_act_store (
    .clk      (clk),
    .reset    (reset),
    .act_wr_i (act_wr_i),
    .job_rd_i (job_rd),
    .take_i   (take),
    .pos_i    (scan_pos),
    .act_o    (act)
  );

  flag_scanner u_flag_scanner (
    .clk        (clk),
    .reset      (reset),
    .load_i     (scan_load),
    .mask_i     (mask),
    .take_o     (take),
    .pos_o      (scan_pos),
    .last_o     (last),
    .nz_count_o (scan_count)
  );

  feed_ctrl u_feed_ctrl (
    .clk         (clk),
    .reset       (reset),
    .start_i     (start_i),
    .take_i      (take),
    .last_i      (last),
    .nz_count_i  (scan_count),
    .job_rd_o    (job_rd),
    .scan_load_o (scan_load),
    .busy_o      (busy_o),
    .valid_o     (valid_o),
    .done_o      (done_o),
    .nz_count_o  (nz_count_o),
    .zero_o      (zero_o)
  );

  // tap position delayed like the store reads
  always_ff @(posedge clk) begin
    if (take) begin
      beat_pos <= scan_pos;
    end
  end

  assign beat_o = '{weight: weight, act: act, pos: beat_pos};

endmodule

// File: src/feed_ctrl.sv
`timescale 1ns/100ps

module feed_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start_i,
  input  logic                      take_i,
  input  logic                      last_i,
  input  sparse_feeder_pkg::count_t nz_count_i,
  output logic                      job_rd_o,
  output logic                      scan_load_o,
  output logic                      busy_o,
  output logic                      valid_o,
  output logic                      done_o,
  output sparse_feeder_pkg::count_t nz_count_o,
  output logic                      zero_o
);

  import sparse_feeder_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,   // flag word and block read
    ST_LOAD,   // scanner takes the mask
    ST_SCAN,   // one beat per set bit
    ST_DRAIN   // last beat on the outputs
  } state_t;

  state_t state;
  logic   zero_job;

  // a loaded mask with no set bits ends the job right away
  assign zero_job = (state == ST_SCAN) && (nz_count_i == '0);

  // ------------------------------------------------------------
  // job FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (start_i) state <= ST_READ;  // start ignored while busy
        ST_READ:  state <= ST_LOAD;
        ST_LOAD:  state <= ST_SCAN;
        ST_SCAN: begin
          if (zero_job) state <= ST_IDLE;
          else if (take_i && last_i) state <= ST_DRAIN;
        end
        ST_DRAIN: state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  assign job_rd_o    = (state == ST_READ);
  assign scan_load_o = (state == ST_LOAD);
  assign busy_o      = (state != ST_IDLE);

  // valid lines up with the registered store outputs
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      valid_o    <= 1'b0;
      done_o     <= 1'b0;
      zero_o     <= 1'b0;
      nz_count_o <= '0;
    end else begin
      valid_o <= take_i;
      done_o  <= (state == ST_DRAIN) || zero_job;
      zero_o  <= zero_job;
      if ((state == ST_DRAIN) || zero_job) begin
        nz_count_o <= nz_count_i;  // held through done
      end
    end
  end

endmodule

// File: sparsity/flag_scanner.sv
`timescale 1ns/100ps
`include "sparse_feeder_macros.svh"

module flag_scanner (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_i,
  input  sparse_feeder_pkg::flag_mask_t mask_i,
  output logic                          take_o,
  output sparse_feeder_pkg::pos_t       pos_o,
  output logic                          last_o,
  output sparse_feeder_pkg::count_t     nz_count_o
);

  import sparse_feeder_pkg::*;

  flag_mask_t mask_q;    // taps still to emit
  flag_mask_t low_bit;
  flag_mask_t rest;
  count_t     ones;

  // ------------------------------------------------------------
  // lowest set bit
  // ------------------------------------------------------------
  assign low_bit = mask_q & (~mask_q + 1'b1);  // isolate lowest one
  assign rest    = mask_q & (mask_q - 1'b1);   // mask with it cleared

  always_comb begin
    pos_o = '0;
    for (int i = 0; i < `SF_KERNEL_SIZE; i++) begin
      if (low_bit[i]) pos_o = pos_t'(i);
    end
  end

  // popcount of the incoming mask
  always_comb begin
    ones = '0;
    for (int i = 0; i < `SF_KERNEL_SIZE; i++) begin
      ones = ones + count_t'(mask_i[i]);
    end
  end

  assign take_o = (mask_q != '0);
  assign last_o = take_o && (rest == '0);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      mask_q     <= '0;
      nz_count_o <= '0;
    end else if (load_i) begin
      mask_q     <= mask_i;
      nz_count_o <= ones;
    end else if (take_o) begin
      mask_q <= rest;  // one tap per cycle
    end
  end

endmodule

// File: storage/act_store.sv
`timescale 1ns/100ps
`include "sparse_feeder_macros.svh"

module act_store (
  input  logic                       clk,
  input  logic                       reset,
  input  sparse_feeder_pkg::act_wr_t act_wr_i,
  input  logic                       job_rd_i,
  input  logic                       take_i,
  input  sparse_feeder_pkg::pos_t    pos_i,
  output sparse_feeder_pkg::pix_t    act_o
);

  import sparse_feeder_pkg::*;

  logic [`SF_FLAG_ADDR_WIDTH-1:0] wr_ptr;
  logic [`SF_FLAG_ADDR_WIDTH-1:0] rd_ptr;
  act_block_t                     block;
  pos_t                           pos_q;

  // ------------------------------------------------------------
  // block pointers for one block per job
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (act_wr_i.valid) wr_ptr <= wr_ptr + 1'b1;
      if (job_rd_i)       rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // whole 3x3 block in one wide word
  sp_ram #(
    .DATA_WIDTH ($bits(act_block_t)),
    .ADDR_WIDTH (`SF_FLAG_ADDR_WIDTH)
  ) u_act_ram (
    .clk       (clk),
    .reset     (reset),
    .wr_en_i   (act_wr_i.valid),
    .wr_addr_i (wr_ptr),
    .wr_data_i (act_wr_i.block),
    .rd_en_i   (job_rd_i),
    .rd_addr_i (rd_ptr),
    .rd_data_o (block)
  );

  // position follows the weight read by one cycle
  always_ff @(posedge clk) begin
    if (take_i) begin
      pos_q <= pos_i;
    end
  end

  assign act_o = block[pos_q];  // block held until next job read

endmodule

// File: storage/weight_store.sv
`timescale 1ns/100ps
`include "sparse_feeder_macros.svh"

module weight_store (
  input  logic                          clk,
  input  logic                          reset,
  input  sparse_feeder_pkg::flag_wr_t   flag_wr_i,
  input  sparse_feeder_pkg::wei_wr_t    wei_wr_i,
  input  logic                          job_rd_i,
  input  logic                          take_i,
  output sparse_feeder_pkg::flag_mask_t mask_o,
  output sparse_feeder_pkg::pix_t       weight_o
);

  import sparse_feeder_pkg::*;

  logic [`SF_FLAG_ADDR_WIDTH-1:0] flag_wr_addr;
  logic [`SF_FLAG_ADDR_WIDTH-1:0] job_ptr;
  logic [`SF_WEI_ADDR_WIDTH-1:0]  wei_wr_addr;
  logic [`SF_WEI_ADDR_WIDTH-1:0]  wei_rd_addr;

  // ------------------------------------------------------------
  // address counters
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      flag_wr_addr <= '0;
      job_ptr      <= '0;
      wei_wr_addr  <= '0;
      wei_rd_addr  <= '0;
    end else begin
      if (flag_wr_i.valid) flag_wr_addr <= flag_wr_addr + 1'b1;
      if (job_rd_i)        job_ptr      <= job_ptr + 1'b1;
      if (wei_wr_i.valid)  wei_wr_addr  <= wei_wr_addr + 1'b1;
      // one step per beat and carried across jobs
      if (take_i)          wei_rd_addr  <= wei_rd_addr + 1'b1;
    end
  end

  sp_ram #(
    .DATA_WIDTH ($bits(flag_mask_t)),
    .ADDR_WIDTH (`SF_FLAG_ADDR_WIDTH)
  ) u_flag_ram (
    .clk       (clk),
    .reset     (reset),
    .wr_en_i   (flag_wr_i.valid),
    .wr_addr_i (flag_wr_addr),
    .wr_data_i (flag_wr_i.mask),
    .rd_en_i   (job_rd_i),
    .rd_addr_i (job_ptr),
    .rd_data_o (mask_o)
  );

  sp_ram #(
    .DATA_WIDTH ($bits(pix_t)),
    .ADDR_WIDTH (`SF_WEI_ADDR_WIDTH)
  ) u_wei_ram (
    .clk       (clk),
    .reset     (reset),
    .wr_en_i   (wei_wr_i.valid),
    .wr_addr_i (wei_wr_addr),
    .wr_data_i (wei_wr_i.data),
    .rd_en_i   (take_i),     // nonzero weights only
    .rd_addr_i (wei_rd_addr),
    .rd_data_o (weight_o)
  );

endmodule

// File: storage/sp_ram.sv
`timescale 1ns/100ps

module sp_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr_en_i,
  input  logic [ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0] wr_data_i,
  input  logic                  rd_en_i,
  input  logic [ADDR_WIDTH-1:0] rd_addr_i,
  output logic [DATA_WIDTH-1:0] rd_data_o
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read that holds between strobes
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// File: common/sparse_feeder_pkg.sv
`include "sparse_feeder_macros.svh"

package sparse_feeder_pkg;

  typedef logic [`SF_PIX_WIDTH-1:0]   pix_t;
  typedef logic [`SF_KERNEL_SIZE-1:0] flag_mask_t;  // bit p set -> tap p nonzero
  typedef logic [`SF_POS_WIDTH-1:0]   pos_t;
  typedef logic [`SF_POS_WIDTH-1:0]   count_t;      // nonzero taps 0..9

  // one 3x3 pixel block, tap 0 in the low byte
  typedef pix_t [`SF_KERNEL_SIZE-1:0] act_block_t;

  // ------------------------------------------------------------
  // write strobes with sequential addressing
  // ------------------------------------------------------------
  typedef struct packed {
    logic       valid;
    flag_mask_t mask;
  } flag_wr_t;

  typedef struct packed {
    logic valid;
    pix_t data;
  } wei_wr_t;

  typedef struct packed {
    logic       valid;
    act_block_t block;
  } act_wr_t;

  // one output beat
  typedef struct packed {
    pix_t weight;
    pix_t act;
    pos_t pos;   // kernel tap of this pair
  } beat_t;

endpackage

// File: common/sparse_feeder_macros.svh
`ifndef SPARSE_FEEDER_MACROS_SVH
`define SPARSE_FEEDER_MACROS_SVH

// ------------------------------------------------------------
// datapath sizes
// ------------------------------------------------------------

// pixel and weight width
`define SF_PIX_WIDTH 8

// taps in one 3x3 kernel
`define SF_KERNEL_SIZE 9

// tap position 0..8 and also a count of 0..9
`define SF_POS_WIDTH 4

// ------------------------------------------------------------
// store depths
// ------------------------------------------------------------

// 16 jobs in the flag and activation stores
`define SF_FLAG_ADDR_WIDTH 4

// 256 packed nonzero weights
`define SF_WEI_ADDR_WIDTH 8

`endif
